/* files.f */
hdl/dotp_pkg.sv
hdl/tile_sequencer.sv
hdl/dotp_stage.sv
hdl/accum_stage.sv
hdl/requant_stage.sv
hdl/out_fifo.sv
hdl/dotp_top.sv
tb/tb_dotp_top.sv

/* hdl/accum_stage.sv */
//--------------------------------------------------------------------------
// Accumulator over inner tiles, bias loaded on the first tile
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module accum_stage (
  input  wire                  clk_i,
  input  wire                  rst_ni,
  input  dotp_pkg::dotp_beat_t dotp_i,
  output dotp_pkg::acc_res_t   acc_o
);

  logic signed [dotp_pkg::W_ACC-1:0] acc_q;
  logic                              valid_q;
  logic                              seen_first_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q      <= 1'b0;
      seen_first_q <= 1'b0;
    end else begin
      valid_q <= dotp_i.flags.calc_en & dotp_i.flags.last_tile;
      if (dotp_i.flags.calc_en && dotp_i.flags.first_tile) begin
        seen_first_q <= 1'b1;
      end
    end
  end

  // Wraps at 32 bits
  always_ff @(posedge clk_i) begin
    if (dotp_i.flags.calc_en) begin
      if (dotp_i.flags.first_tile) begin
        acc_q <= dotp_i.sum + dotp_i.bias;
      end else begin
        acc_q <= acc_q + dotp_i.sum;
      end
    end
  end

  assign acc_o = '{valid: valid_q, acc: acc_q};

  a_first_before_rest: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (dotp_i.flags.calc_en && !dotp_i.flags.first_tile) |-> seen_first_q)
    else $error("continuation beat arrived before any first tile");

endmodule

`default_nettype wire

/* hdl/dotp_pkg.sv */
//--------------------------------------------------------------------------
// Shared sizes and types for the int8 dot-product inference datapath
//--------------------------------------------------------------------------
`default_nettype none

package dotp_pkg;

  localparam int N_LANES    = 8;
  localparam int W_IN       = 8;
  localparam int W_ACC      = 32;
  localparam int W_EPS      = 8;
  localparam int W_SHIFT    = 5;
  localparam int TILE_W     = 5;
  localparam int W_MUL      = W_ACC + W_EPS;
  localparam int FIFO_DEPTH = 8;
  localparam int FIFO_AW    = $clog2(FIFO_DEPTH);
  localparam int PIPE_DEPTH = 3;

  // Output clipping range
  localparam int RES_MAX = 2 ** (W_IN - 1) - 1;
  localparam int RES_MIN = -(2 ** (W_IN - 1));

  typedef enum logic [0:0] {
    ACT_IDENTITY = 1'b0,
    ACT_RELU     = 1'b1
  } activation_e;

  // Static while a result is being accepted
  typedef struct packed {
    logic [TILE_W-1:0]        inner_tiles;
    logic [W_EPS-1:0]         eps_mult;
    logic [W_SHIFT-1:0]       right_shift;
    logic signed [W_IN-1:0]   add;
    activation_e              activation;
  } ctrl_t;

  typedef logic signed [W_IN-1:0] in_elem_t;

  typedef struct packed {
    in_elem_t [N_LANES-1:0]  inp;
    in_elem_t [N_LANES-1:0]  weight;
    logic signed [W_ACC-1:0] bias;
  } beat_t;

  typedef struct packed {
    logic calc_en;
    logic first_tile;
    logic last_tile;
  } tile_flags_t;

  typedef struct packed {
    tile_flags_t             flags;
    logic signed [W_ACC-1:0] sum;
    logic signed [W_ACC-1:0] bias;
  } dotp_beat_t;

  typedef struct packed {
    logic                    valid;
    logic signed [W_ACC-1:0] acc;
  } acc_res_t;

  typedef logic signed [W_IN-1:0] res_t;

endpackage

`default_nettype wire

/* hdl/dotp_stage.sv */
//--------------------------------------------------------------------------
// Eight-lane signed 8x8 multiply and sum, registered with its flags
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module dotp_stage (
  input  wire                   clk_i,
  input  wire                   rst_ni,
  input  dotp_pkg::beat_t       beat_i,
  input  dotp_pkg::tile_flags_t flags_i,
  output dotp_pkg::dotp_beat_t  dotp_o
);

  logic signed [dotp_pkg::W_ACC-1:0] sum;
  logic signed [dotp_pkg::W_ACC-1:0] sum_q;
  logic signed [dotp_pkg::W_ACC-1:0] bias_q;
  dotp_pkg::tile_flags_t             flags_q;

  always_comb begin
    logic signed [2*dotp_pkg::W_IN-1:0] prod;
    sum = '0;
    for (int i = 0; i < dotp_pkg::N_LANES; i++) begin
      prod = $signed(beat_i.inp[i]) * $signed(beat_i.weight[i]);
      sum  = sum + dotp_pkg::W_ACC'(prod);
    end
  end

  // Flags advance every cycle, data only on enabled beats
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      flags_q <= '0;
    end else begin
      flags_q <= flags_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (flags_i.calc_en) begin
      sum_q  <= sum;
      bias_q <= beat_i.bias;
    end
  end

  assign dotp_o = '{flags: flags_q, sum: sum_q, bias: bias_q};

endmodule

`default_nettype wire

/* hdl/dotp_top.sv */
//--------------------------------------------------------------------------
// Top level of the int8 dot-product datapath
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module dotp_top (
  input  wire             clk_i,
  input  wire             rst_ni,
  input  dotp_pkg::ctrl_t ctrl_i,
  input  wire             inp_valid_i,
  output logic            inp_ready_o,
  input  dotp_pkg::beat_t beat_i,
  output logic            valid_o,
  input  wire             ready_i,
  output dotp_pkg::res_t  oup_o,
  output logic            busy_o
);

  dotp_pkg::beat_t       beat_q;
  dotp_pkg::tile_flags_t flags_q;
  dotp_pkg::dotp_beat_t  dotp;
  dotp_pkg::acc_res_t    acc;
  dotp_pkg::res_t        rq_data;
  logic                  rq_push;
  logic                  space_ok;

  tile_sequencer i_sequencer (
    .clk_i       (clk_i      ),
    .rst_ni      (rst_ni     ),
    .ctrl_i      (ctrl_i     ),
    .inp_valid_i (inp_valid_i),
    .inp_ready_o (inp_ready_o),
    .beat_i      (beat_i     ),
    .space_ok_i  (space_ok   ),
    .beat_o      (beat_q     ),
    .flags_o     (flags_q    ),
    .busy_o      (busy_o     )
  );

  dotp_stage i_dotp (.clk_i(clk_i), .rst_ni(rst_ni), .beat_i(beat_q), .flags_i(flags_q),
                     .dotp_o(dotp));

  accum_stage i_accum (.clk_i(clk_i), .rst_ni(rst_ni), .dotp_i(dotp), .acc_o(acc));

  requant_stage i_requant (.clk_i(clk_i), .rst_ni(rst_ni), .ctrl_i(ctrl_i), .acc_i(acc),
                           .push_o(rq_push), .data_o(rq_data));

  out_fifo i_fifo (
    .clk_i      (clk_i   ),
    .rst_ni     (rst_ni  ),
    .push_i     (rq_push ),
    .data_i     (rq_data ),
    .valid_o    (valid_o ),
    .ready_i    (ready_i ),
    .data_o     (oup_o   ),
    .space_ok_o (space_ok)
  );

endmodule

`default_nettype wire

/* hdl/out_fifo.sv */
//--------------------------------------------------------------------------
// Output FIFO with valid/ready pop and a space reservation flag
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module out_fifo (
  input  wire            clk_i,
  input  wire            rst_ni,
  input  wire            push_i,
  input  dotp_pkg::res_t data_i,
  output logic           valid_o,
  input  wire            ready_i,
  output dotp_pkg::res_t data_o,
  output logic           space_ok_o
);

  dotp_pkg::res_t                mem [dotp_pkg::FIFO_DEPTH];
  logic [dotp_pkg::FIFO_AW-1:0]  wr_ptr_q;
  logic [dotp_pkg::FIFO_AW-1:0]  rd_ptr_q;
  logic [dotp_pkg::FIFO_AW:0]    count_q;
  logic [dotp_pkg::FIFO_AW:0]    count_d;
  logic                          pop;

  assign valid_o = (count_q != '0);
  assign pop     = valid_o & ready_i;
  assign data_o  = mem[rd_ptr_q];

  always_comb begin
    count_d = count_q;
    if (push_i && !pop) begin
      count_d = count_q + 1'b1;
    end else if (!push_i && pop) begin
      count_d = count_q - 1'b1;
    end
  end

  // Free slots must cover the pipeline plus the beat taken this cycle
  assign space_ok_o = count_d <
                      (dotp_pkg::FIFO_AW + 1)'(dotp_pkg::FIFO_DEPTH - dotp_pkg::PIPE_DEPTH);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      count_q <= count_d;
      if (push_i) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop)    rd_ptr_q <= rd_ptr_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) mem[wr_ptr_q] <= data_i;
  end

  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_i |-> (count_q < (dotp_pkg::FIFO_AW + 1)'(dotp_pkg::FIFO_DEPTH)))
    else $error("push into full output FIFO");

endmodule

`default_nettype wire

/* hdl/requant_stage.sv */
//--------------------------------------------------------------------------
// Requantizer: scale, shift, offset and clip to int8, optional ReLU
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module requant_stage (
  input  wire                clk_i,
  input  wire                rst_ni,
  input  dotp_pkg::ctrl_t    ctrl_i,
  input  dotp_pkg::acc_res_t acc_i,
  output logic               push_o,
  output dotp_pkg::res_t     data_o
);

  logic signed [dotp_pkg::W_MUL-1:0] prod;
  logic signed [dotp_pkg::W_MUL-1:0] shifted;
  logic signed [dotp_pkg::W_MUL:0]   biased;
  dotp_pkg::res_t                    clipped;
  dotp_pkg::res_t                    act;
  logic                              push_q;
  dotp_pkg::res_t                    data_q;

  always_comb begin
    // eps_mult is unsigned, so zero-extend before the signed multiply
    prod    = acc_i.acc * $signed({1'b0, ctrl_i.eps_mult});
    shifted = prod >>> ctrl_i.right_shift;
    biased  = shifted + ctrl_i.add;

    if (biased > dotp_pkg::RES_MAX) begin
      clipped = dotp_pkg::res_t'(dotp_pkg::RES_MAX);
    end else if (biased < dotp_pkg::RES_MIN) begin
      clipped = dotp_pkg::res_t'(dotp_pkg::RES_MIN);
    end else begin
      clipped = biased[dotp_pkg::W_IN-1:0];
    end

    if (ctrl_i.activation == dotp_pkg::ACT_RELU && clipped < 0) begin
      act = '0;
    end else begin
      act = clipped;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      push_q <= 1'b0;
    end else begin
      push_q <= acc_i.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (acc_i.valid) begin
      data_q <= act;
    end
  end

  assign push_o = push_q;
  assign data_o = data_q;

endmodule

`default_nettype wire

/* hdl/tile_sequencer.sv */
//--------------------------------------------------------------------------
// Tile sequencer: takes input beats and counts inner tiles per result,
// tagging each beat with its enable and first/last tile flags
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tile_sequencer (
  input  wire                   clk_i,
  input  wire                   rst_ni,
  input  dotp_pkg::ctrl_t       ctrl_i,
  input  wire                   inp_valid_i,
  output logic                  inp_ready_o,
  input  dotp_pkg::beat_t       beat_i,
  input  wire                   space_ok_i,
  output dotp_pkg::beat_t       beat_o,
  output dotp_pkg::tile_flags_t flags_o,
  output logic                  busy_o
);

  logic [dotp_pkg::TILE_W-1:0] cnt_q;
  logic                        ready_en_q;
  logic                        accept;
  logic                        is_first;
  logic                        is_last;

  // Held low through reset, then follows the FIFO reservation
  assign inp_ready_o = ready_en_q & space_ok_i;
  assign accept      = inp_valid_i & inp_ready_o;
  assign is_first    = (cnt_q == '0);
  assign is_last     = ((cnt_q + 1'b1) == ctrl_i.inner_tiles);
  assign busy_o      = (cnt_q != '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q      <= '0;
      ready_en_q <= 1'b0;
      flags_o    <= '0;
    end else begin
      ready_en_q         <= 1'b1;
      flags_o.calc_en    <= accept;
      flags_o.first_tile <= accept & is_first;
      flags_o.last_tile  <= accept & is_last;
      if (accept) begin
        cnt_q <= is_last ? '0 : cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      beat_o <= beat_i;
    end
  end

  a_cnt_in_range: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cnt_q < ctrl_i.inner_tiles)
    else $error("tile counter reached inner_tiles");

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# Build and run the dot-product testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_dotp_top \
  -f files.f -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vtb_dotp_top)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "All tests passed"; then
  exit 0
fi
exit 1

/* tb/tb_dotp_top.sv */
//--------------------------------------------------------------------------
// Testbench for the int8 dot-product datapath: table-driven results,
// a requantization model, and output back-pressure
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_dotp_top;

  localparam int          N_ENT     = 24;
  localparam int          MAX_TILES = 16;
  localparam int          TIMEOUT   = 2000;
  localparam logic [31:0] SEED      = 32'h13ee_0d96;

  typedef struct packed {
    dotp_pkg::ctrl_t    ctrl;
    int                 seed_ofs;
    logic signed [31:0] bias;
    int                 stall;
  } entry_t;

  logic                  clk_i;
  logic                  rst_ni;
  dotp_pkg::ctrl_t       ctrl_i;
  logic                  inp_valid_i;
  logic                  inp_ready_o;
  dotp_pkg::beat_t       beat_i;
  logic                  valid_o;
  logic                  ready_i;
  dotp_pkg::res_t        oup_o;
  logic                  busy_o;

  entry_t                table_q [N_ENT];
  logic signed [7:0]     exp_q [$];
  int                    errors;
  int                    received;
  int                    issued;
  int                    extra;
  bit                    saw_ready_low;

  dotp_top UUT (
    .clk_i       (clk_i      ),
    .rst_ni      (rst_ni     ),
    .ctrl_i      (ctrl_i     ),
    .inp_valid_i (inp_valid_i),
    .inp_ready_o (inp_ready_o),
    .beat_i      (beat_i     ),
    .valid_o     (valid_o    ),
    .ready_i     (ready_i    ),
    .oup_o       (oup_o      ),
    .busy_o      (busy_o     )
  );

  always #2 clk_i = ~clk_i;

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expv);
    if (got !== expv) begin
      errors++;
      $display("FAIL %s: got 0x%08h, expected 0x%08h", name, got, expv);
    end
  endtask

  function automatic entry_t make_entry(int tiles, int eps, int shift, int add,
                                        dotp_pkg::activation_e act, int ofs, int bias,
                                        int stall);
    entry_t e;
    e.ctrl.inner_tiles = 5'(tiles);
    e.ctrl.eps_mult    = 8'(eps);
    e.ctrl.right_shift = 5'(shift);
    e.ctrl.add         = 8'(add);
    e.ctrl.activation  = act;
    e.seed_ofs         = ofs;
    e.bias             = bias;
    e.stall            = stall;
    return e;
  endfunction

  // Scale, floor shift, offset, clip to int8, then optional ReLU
  function automatic dotp_pkg::res_t requant_model(dotp_pkg::ctrl_t c,
                                                   logic signed [31:0] acc);
    longint scaled;
    longint biased;
    scaled = longint'(acc) * longint'(c.eps_mult);
    scaled = scaled >>> c.right_shift;
    biased = scaled + longint'(c.add);
    if (biased > 127) biased = 127;
    else if (biased < -128) biased = -128;
    if (c.activation == dotp_pkg::ACT_RELU && biased < 0) biased = 0;
    return dotp_pkg::res_t'(biased[7:0]);
  endfunction

  task automatic send_entry(input int idx);
    dotp_pkg::beat_t    beats [MAX_TILES];
    entry_t             e;
    integer             seed;
    logic [31:0]        r;
    logic signed [15:0] prod;
    logic signed [31:0] acc;
    int                 cnt;
    e    = table_q[idx];
    seed = SEED + e.seed_ofs;
    acc  = e.bias;
    for (int t = 0; t < int'(e.ctrl.inner_tiles); t++) begin
      beats[t].bias = e.bias;
      for (int l = 0; l < dotp_pkg::N_LANES; l++) begin
        r                  = $random(seed);
        beats[t].inp[l]    = r[7:0];
        beats[t].weight[l] = r[15:8];
        prod               = beats[t].inp[l] * beats[t].weight[l];
        acc                = acc + 32'(prod);
      end
    end
    exp_q.push_back(requant_model(e.ctrl, acc));
    // Results still in flight read ctrl_i in the requantizer
    if (ctrl_i != e.ctrl) begin
      cnt = 0;
      #1;
      while (received != issued && cnt < TIMEOUT) begin
        @(negedge clk_i);
        #1;
        cnt++;
      end
      if (received != issued) begin
        errors++;
        $display("Timeout waiting for the pipeline to drain before entry %0d", idx);
      end
      @(negedge clk_i);
      ctrl_i = e.ctrl;
    end
    for (int t = 0; t < int'(e.ctrl.inner_tiles); t++) begin
      inp_valid_i = 1'b1;
      beat_i      = beats[t];
      cnt         = 0;
      #1;
      while (!inp_ready_o && cnt < TIMEOUT) begin
        saw_ready_low = 1'b1;
        @(negedge clk_i);
        #1;
        cnt++;
      end
      if (!inp_ready_o) begin
        errors++;
        $display("Timeout waiting for inp_ready_o on entry %0d beat %0d", idx, t);
      end
      @(negedge clk_i);
      // Busy while the result is only partly accepted
      check_value("busy_o", 32'(busy_o), 32'(t + 1 < int'(e.ctrl.inner_tiles)));
    end
    inp_valid_i = 1'b0;
    issued++;
  endtask

  task automatic receive_all();
    logic signed [7:0] expv;
    int                cnt;
    bit                got;
    for (int k = 0; k < N_ENT; k++) begin
      for (int s = 0; s < table_q[k].stall; s++) begin
        @(negedge clk_i);
        ready_i = 1'b0;
      end
      cnt = 0;
      got = 1'b0;
      // Handshake completes at the next rising edge
      while (!got && cnt < TIMEOUT) begin
        @(negedge clk_i);
        ready_i = 1'b1;
        got     = valid_o;
        cnt++;
      end
      if (!got) begin
        errors++;
        $display("Timeout waiting for result %0d on valid_o", k);
      end else if (exp_q.size() == 0) begin
        errors++;
        $display("Result %0d arrived with no expected value queued", k);
      end else begin
        expv = exp_q.pop_front();
        check_value($sformatf("oup_o[%0d]", k), 32'(oup_o), 32'(expv));
        received++;
      end
    end
    extra = 0;
    repeat (20) begin
      @(negedge clk_i);
      if (valid_o) extra++;
    end
    check_value("extra_outputs", 32'(extra), 32'd0);
  endtask

  initial begin
    clk_i         = 1'b0;
    rst_ni        = 1'b0;
    inp_valid_i   = 1'b0;
    ready_i       = 1'b0;
    beat_i        = '0;
    errors        = 0;
    received      = 0;
    issued        = 0;
    saw_ready_low = 1'b0;
    //                     tiles eps shift add activation           ofs bias      stall
    table_q[0]  = make_entry(1,  1,   0,   0, dotp_pkg::ACT_IDENTITY, 0,  0,        0);
    table_q[1]  = make_entry(1,  1,   0,   0, dotp_pkg::ACT_IDENTITY, 1,  -20,      3);
    table_q[2]  = make_entry(16, 1,   12,  0, dotp_pkg::ACT_IDENTITY, 2,  1000,     0);
    table_q[3]  = make_entry(16, 3,   13, -7, dotp_pkg::ACT_IDENTITY, 3,  5000,     2);
    table_q[4]  = make_entry(4,  200, 4,   5, dotp_pkg::ACT_IDENTITY, 4,  1000000,  0);
    table_q[5]  = make_entry(4,  200, 4,   5, dotp_pkg::ACT_IDENTITY, 5,  -1000000, 0);
    table_q[6]  = make_entry(2,  1,   0,   0, dotp_pkg::ACT_RELU,     6,  -1000000, 0);
    table_q[7]  = make_entry(2,  1,   12,  0, dotp_pkg::ACT_RELU,     7,  400000,   0);
    table_q[8]  = make_entry(2,  1,   12,  0, dotp_pkg::ACT_RELU,     8,  -3000,    0);
    for (int i = 9; i < N_ENT; i++) begin
      table_q[i] = make_entry(1, 1, 10, 3, dotp_pkg::ACT_IDENTITY, i, 0,
                              (i == 9 || i == 13) ? 40 : 0);
    end
    ctrl_i = table_q[0].ctrl;

    repeat (10) @(negedge clk_i);
    check_value("valid_o", 32'(valid_o), 32'd0);
    check_value("busy_o", 32'(busy_o), 32'd0);
    check_value("inp_ready_o", 32'(inp_ready_o), 32'd0);
    rst_ni = 1'b1;
    #1;
    check_value("inp_ready_o", 32'(inp_ready_o), 32'd0);
    @(negedge clk_i);

    fork
      begin
        for (int i = 0; i < N_ENT; i++) send_entry(i);
      end
      receive_all();
    join
    check_value("saw_inp_ready_low", 32'(saw_ready_low), 32'd1);

    $display("Errors: %0d, results checked: %0d of %0d", errors, received, N_ENT);
    if (errors == 0 && received == N_ENT) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
